/* Bender.yml */
package:
  name: headFifo

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/headFifoPkg.sv
      - design/fifoCtrlIf.sv
      - design/fifoOccupancy.sv
      - design/fifoStorage.sv
      - design/headFifo.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/headFifoClockGen.sv
      - testbench/headFifoTb.sv

/* design/fifoCtrlIf.sv */
`timescale 1ns/10ps
`default_nettype none

// per-cycle commands from occupancy control to the storage side
interface fifoCtrlIf;

   // store dataIn at the write pointer
   logic write;
   // load dataIn straight into the head register
   logic headFromInput;
   // load the word at the read pointer into the head register
   logic headFromMem;
   // zero both pointers and the head
   logic clear;

   modport ctrl (
      output write,
      output headFromInput,
      output headFromMem,
      output clear
   );

   modport store (
      input write,
      input headFromInput,
      input headFromMem,
      input clear
   );

endinterface

`default_nettype wire

/* design/fifoOccupancy.sv */
`timescale 1ns/10ps
`default_nettype none

`include "headFifo_macros.svh"

module fifoOccupancy
   import headFifoPkg::*;
(
   input  logic clkin,
   input  logic reset_n,
   input  logic flush,
   input  logic wrEn,
   input  logic rdEn,
   fifoCtrlIf.ctrl ctrl,
   output logic empty,
   output logic almostEmpty,
   output logic full,
   output logic almostFull
);

   fifoCount_t count;
   fifoCount_t countNext;

   logic wrOk;
   logic rdOk;

   logic emptyNext;
   logic almostEmptyNext;
   logic fullNext;
   logic almostFullNext;

   // requests are judged against the registered flags
   assign wrOk = wrEn & ~full;
   assign rdOk = rdEn & ~empty;

   // next occupancy
   always_comb begin
      countNext = count;
      if (flush) begin
         countNext = '0;
      end else begin
         case ({wrOk, rdOk})
            2'b10: countNext = count + fifoCount_t'(1);
            2'b01: countNext = count - fifoCount_t'(1);
            // both or neither leave the count alone
            default: countNext = count;
         endcase
      end
   end

   always_ff @(posedge clkin) begin
      if (!reset_n) begin
         count <= '0;
      end else begin
         count <= countNext;
      end
   end

   // flags follow the count that will be there after this edge
   always_comb begin
      emptyNext       = (countNext == '0);
      almostEmptyNext = (countNext <= fifoCount_t'(`FIFO_AE_THRESHOLD));
      fullNext        = (countNext == fifoCount_t'(`FIFO_DEPTH));
      almostFullNext  = (countNext > fifoCount_t'(`FIFO_AF_THRESHOLD));
   end

   always_ff @(posedge clkin) begin
      if (!reset_n) begin
         empty       <= 1'b1;
         almostEmpty <= 1'b1;
         full        <= 1'b0;
         almostFull  <= 1'b0;
      end else begin
         empty       <= emptyNext;
         almostEmpty <= almostEmptyNext;
         full        <= fullNext;
         almostFull  <= almostFullNext;
      end
   end

   // storage commands, flush wins over everything else
   always_comb begin
      ctrl.clear         = flush;
      ctrl.write         = 1'b0;
      ctrl.headFromInput = 1'b0;
      ctrl.headFromMem   = 1'b0;
      if (!flush) begin
         ctrl.write = wrOk;

         // head is empty or about to be, so the new word bypasses memory
         if (wrOk && ((count == '0) || ((count == fifoCount_t'(1)) && rdOk))) begin
            ctrl.headFromInput = 1'b1;
         end

         // next-oldest word comes up from memory
         // last word leaving alone keeps the stale head and the read pointer
         if (rdOk && (count > fifoCount_t'(1))) begin
            ctrl.headFromMem = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* design/fifoStorage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "headFifo_macros.svh"

module fifoStorage
   import headFifoPkg::*;
(
   input  logic      clkin,
   input  logic      reset_n,
   fifoCtrlIf.store  store,
   input  fifoWord_t dataIn,
   output fifoWord_t dataOut
);

   fifoWord_t mem [`FIFO_DEPTH];

   fifoPtr_t wrPtr;
   fifoPtr_t rdPtr;

   fifoWord_t head;

   logic headLoad;

   // every head load consumes one slot behind the head
   assign headLoad = store.headFromInput | store.headFromMem;

   // storage array, no reset
   always_ff @(posedge clkin) begin
      if (store.write) begin
         mem[wrPtr] <= dataIn;
      end
   end

   // write pointer wraps at the power-of-two depth
   always_ff @(posedge clkin) begin
      if (!reset_n || store.clear) begin
         wrPtr <= '0;
      end else if (store.write) begin
         wrPtr <= wrPtr + fifoPtr_t'(1);
      end
   end

   // read pointer marks the oldest word still in memory
   always_ff @(posedge clkin) begin
      if (!reset_n || store.clear) begin
         rdPtr <= '0;
      end else if (headLoad) begin
         rdPtr <= rdPtr + fifoPtr_t'(1);
      end
   end

   // head register, oldest entry shown without a read cycle
   always_ff @(posedge clkin) begin
      if (!reset_n || store.clear) begin
         head <= '0;
      end else if (store.headFromInput) begin
         head <= dataIn;
      end else if (store.headFromMem) begin
         head <= mem[rdPtr];
      end
   end

   assign dataOut = head;

endmodule

`default_nettype wire

/* design/headFifo.sv */
`timescale 1ns/10ps
`default_nettype none

module headFifo
   import headFifoPkg::*;
(
   input  logic      clkin,
   input  logic      reset_n,
   input  logic      flush,
   input  logic      wrEn,
   input  fifoWord_t dataIn,
   input  logic      rdEn,
   output fifoWord_t dataOut,
   output logic      empty,
   output logic      almostEmpty,
   output logic      full,
   output logic      almostFull
);

   // commands from occupancy control to storage
   fifoCtrlIf ctrlBus ();

   // accepts requests, keeps the count and the flags
   fifoOccupancy occupancy (
      .clkin       (clkin),
      .reset_n     (reset_n),
      .flush       (flush),
      .wrEn        (wrEn),
      .rdEn        (rdEn),
      .ctrl        (ctrlBus.ctrl),
      .empty       (empty),
      .almostEmpty (almostEmpty),
      .full        (full),
      .almostFull  (almostFull)
   );

   // array, pointers and head register
   fifoStorage storage (
      .clkin   (clkin),
      .reset_n (reset_n),
      .store   (ctrlBus.store),
      .dataIn  (dataIn),
      .dataOut (dataOut)
   );

endmodule

`default_nettype wire

/* design/headFifoPkg.sv */
`default_nettype none

`include "headFifo_macros.svh"

package headFifoPkg;

   // one stored word, also the head register
   typedef logic [`FIFO_DATA_WIDTH-1:0] fifoWord_t;

   // storage address
   typedef logic [`FIFO_PTR_WIDTH-1:0] fifoPtr_t;

   // occupancy, one extra bit so a full FIFO reads as FIFO_DEPTH
   typedef logic [`FIFO_PTR_WIDTH:0] fifoCount_t;

endpackage

`default_nettype wire

/* design/headFifo_macros.svh */
`ifndef HEAD_FIFO_MACROS_SVH
`define HEAD_FIFO_MACROS_SVH

// data word width in bits
`define FIFO_DATA_WIDTH 32

// number of entries, power of two so the pointers wrap on their own
`define FIFO_DEPTH 16
`define FIFO_PTR_WIDTH 4

// almostEmpty while count <= this value
`define FIFO_AE_THRESHOLD 4
// almostFull while count > this value
`define FIFO_AF_THRESHOLD 14

`endif

/* headFifo.f */
+incdir+design
design/headFifoPkg.sv
design/fifoCtrlIf.sv
design/fifoOccupancy.sv
design/fifoStorage.sv
design/headFifo.sv
testbench/headFifoClockGen.sv
testbench/headFifoTb.sv

/* testbench/headFifoClockGen.sv */
`timescale 1ns/10ps
`default_nettype none

// clock and reset source for the FIFO testbench
module headFifoClockGen (
   output logic clkin,
   output logic reset_n
);

   // 100 ns period
   initial begin
      clkin = 1'b0;
      forever #50 clkin = ~clkin;
   end

   // reset held low for two rising edges
   initial begin
      reset_n = 1'b0;
      repeat (2) @(posedge clkin);
      reset_n <= 1'b1;
   end

endmodule

`default_nettype wire

/* testbench/headFifoTb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "headFifo_macros.svh"

module headFifoTb
   import headFifoPkg::*;
();

   logic      clkin;
   logic      reset_n;
   logic      flush;
   logic      wrEn;
   logic      rdEn;
   fifoWord_t dataIn;
   fifoWord_t dataOut;
   logic      empty;
   logic      almostEmpty;
   logic      full;
   logic      almostFull;

   // reference contents, oldest word at index 0
   fifoWord_t model[$];

   int       errorCount = 0;
   int       checkCount = 0;
   int       testCount = 0;
   int       testErrStart = 0;
   int       seed;
   bit       timedOut = 1'b0;
   bit       modelWr;
   bit       modelRd;
   logic [3:0] expFlags;

   headFifoClockGen clockGen (
      .clkin   (clkin),
      .reset_n (reset_n)
   );

   headFifo i_dut (
      .clkin       (clkin),
      .reset_n     (reset_n),
      .flush       (flush),
      .wrEn        (wrEn),
      .dataIn      (dataIn),
      .rdEn        (rdEn),
      .dataOut     (dataOut),
      .empty       (empty),
      .almostEmpty (almostEmpty),
      .full        (full),
      .almostFull  (almostFull)
   );

   // expected {empty, almostEmpty, full, almostFull} for a given fill level
   function automatic logic [3:0] expectFlags(input int count);
      logic [3:0] flags;
      flags[3] = (count == 0);
      flags[2] = (count <= `FIFO_AE_THRESHOLD);
      flags[1] = (count == `FIFO_DEPTH);
      flags[0] = (count > `FIFO_AF_THRESHOLD);
      return flags;
   endfunction

   function automatic fifoWord_t wordOf(input int i);
      return fifoWord_t'(32'hC0DE0000 + i);
   endfunction

   function automatic logic flagOf(input int which);
      case (which)
         0: return reset_n;
         1: return full;
         default: return empty;
      endcase
   endfunction

   task automatic reportMismatch(input string msg);
      errorCount++;
      $display("Mismatch at %0t: %s", $time, msg);
   endtask

   task automatic reportFailure(input string msg);
      errorCount++;
      $display("%s", msg);
   endtask

   // poll a status signal at falling edges, give up after limit cycles
   task automatic waitFor(input int which, input string what, input int limit);
      int n;
      n = 0;
      while (flagOf(which) !== 1'b1 && n < limit) begin
         @(negedge clkin);
         n++;
      end
      if (flagOf(which) !== 1'b1) begin
         $display("Timeout at %0t: %s did not happen within %0d cycles", $time, what, limit);
         timedOut = 1'b1;
      end
   endtask

   task automatic endTest(input string name);
      testCount++;
      if (timedOut)
         $display("%s: stopped by timeout", name);
      else if (errorCount == testErrStart)
         $display("%s: ok", name);
      else
         $display("%s: %0d errors", name, errorCount - testErrStart);
      testErrStart = errorCount;
   endtask

   // reference model, same acceptance rule as the DUT, judged before the edge
   always @(posedge clkin) begin
      if (!reset_n || flush) begin
         model.delete();
      end else begin
         modelWr = wrEn && (model.size() < `FIFO_DEPTH);
         modelRd = rdEn && (model.size() > 0);
         if (modelRd)
            void'(model.pop_front());
         if (modelWr)
            model.push_back(dataIn);
      end
   end

   // compare flags and head on every falling edge after reset
   always @(negedge clkin) begin
      if (reset_n === 1'b1) begin
         expFlags = expectFlags(model.size());
         checkCount++;
         if ({empty, almostEmpty, full, almostFull} !== expFlags)
            reportMismatch($sformatf("flags %b expected %b at count %0d",
               {empty, almostEmpty, full, almostFull}, expFlags, model.size()));
         if (empty === 1'b0 && model.size() > 0 && dataOut !== model[0])
            reportMismatch($sformatf("dataOut %h expected %h", dataOut, model[0]));
      end
   end

   task automatic resetTest;
      waitFor(0, "reset release", 10);
      @(negedge clkin);
      if (empty !== 1'b1 || almostEmpty !== 1'b1 || full !== 1'b0 || almostFull !== 1'b0)
         reportMismatch("flags not in reset state");
      if (dataOut !== '0)
         reportMismatch($sformatf("dataOut %h after reset, expected zero", dataOut));
      endTest("test 1 reset");
   endtask

   task automatic fillTest;
      for (int i = 0; i < `FIFO_DEPTH; i++) begin
         @(posedge clkin);
         wrEn   <= 1'b1;
         dataIn <= wordOf(i);
      end
      // overflow attempts, must be dropped
      for (int i = 0; i < 4; i++) begin
         @(posedge clkin);
         wrEn   <= 1'b1;
         dataIn <= fifoWord_t'(32'hDEAD0000 + i);
      end
      @(posedge clkin);
      wrEn <= 1'b0;
      waitFor(1, "full", 5);
      @(negedge clkin);
      // oldest word must survive the dropped writes
      if (dataOut !== wordOf(0))
         reportMismatch($sformatf("dataOut %h after overflow, expected %h", dataOut, wordOf(0)));
      endTest("test 2 fill");
   endtask

   task automatic drainTest;
      @(posedge clkin);
      rdEn <= 1'b1;
      for (int i = 0; i < `FIFO_DEPTH; i++) begin
         @(negedge clkin);
         if (dataOut !== wordOf(i))
            reportMismatch($sformatf("drain word %0d is %h, expected %h", i, dataOut, wordOf(i)));
      end
      waitFor(2, "empty after drain", 5);
      // underflow attempts
      repeat (3) @(posedge clkin);
      rdEn <= 1'b0;
      endTest("test 3 drain");
   endtask

   task automatic randomTest;
      int hitOne;
      int hitZero;
      int hitFull;
      hitOne = 0;
      hitZero = 0;
      hitFull = 0;
      for (int cyc = 0; cyc < 300; cyc++) begin
         @(negedge clkin);
         if (model.size() == 1)
            hitOne++;
         if (model.size() == 0)
            hitZero++;
         if (model.size() == `FIFO_DEPTH)
            hitFull++;
         @(posedge clkin);
         // write heavy, then read heavy, then balanced
         if (cyc < 100) begin
            wrEn <= ($urandom % 4) != 0;
            rdEn <= ($urandom % 4) == 0;
         end else if (cyc < 200) begin
            wrEn <= ($urandom % 4) == 0;
            rdEn <= ($urandom % 4) != 0;
         end else begin
            wrEn <= ($urandom % 2) != 0;
            rdEn <= ($urandom % 2) != 0;
         end
         dataIn <= $urandom;
      end
      @(posedge clkin);
      wrEn <= 1'b0;
      rdEn <= 1'b0;
      if (hitOne == 0 || hitZero == 0 || hitFull == 0)
         reportFailure("random run did not reach the count one, empty and full boundaries");
      endTest("test 4 random");
   endtask

   task automatic flushTest;
      for (int i = 0; i < 6; i++) begin
         @(posedge clkin);
         wrEn   <= 1'b1;
         rdEn   <= (i >= 3);
         dataIn <= wordOf(200 + i);
      end
      // flush beats a write and a read in the same cycle
      @(posedge clkin);
      flush  <= 1'b1;
      wrEn   <= 1'b1;
      rdEn   <= 1'b1;
      dataIn <= fifoWord_t'(32'hBAD0BAD0);
      @(posedge clkin);
      flush <= 1'b0;
      wrEn  <= 1'b0;
      rdEn  <= 1'b0;
      @(negedge clkin);
      if (empty !== 1'b1 || almostEmpty !== 1'b1)
         reportMismatch("FIFO not empty one edge after flush");
      for (int i = 0; i < 5; i++) begin
         @(posedge clkin);
         wrEn   <= 1'b1;
         dataIn <= wordOf(300 + i);
      end
      @(posedge clkin);
      wrEn <= 1'b0;
      rdEn <= 1'b1;
      for (int i = 0; i < 5; i++) begin
         @(negedge clkin);
         if (dataOut !== wordOf(300 + i))
            reportMismatch($sformatf("post-flush word %0d is %h, expected %h",
               i, dataOut, wordOf(300 + i)));
      end
      waitFor(2, "empty after post-flush drain", 5);
      @(posedge clkin);
      rdEn <= 1'b0;
      endTest("test 5 flush");
   endtask

   initial begin
      seed   = $urandom(26);
      flush  = 1'b0;
      wrEn   = 1'b0;
      rdEn   = 1'b0;
      dataIn = '0;

      resetTest();
      if (!timedOut)
         fillTest();
      if (!timedOut)
         drainTest();
      if (!timedOut)
         randomTest();
      if (!timedOut)
         flushTest();

      $display("tests %0d, checks %0d, errors %0d, timeout %0d",
         testCount, checkCount, errorCount, timedOut);
      if (errorCount == 0 && !timedOut) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
